// File: design/npc_settings.svh
// global widths and reset values of the npc core, included by every design file that sizes a port
`ifndef NPC_SETTINGS_SVH
`define NPC_SETTINGS_SVH

// datapath and pc width, rv64
`define NPC_WORD_WD 64

// instruction width
`define NPC_INST_WD 32

// general-purpose register address width
`define NPC_GPR_ADDR_WD 5

// first fetch address after reset
`define NPC_PC_RESETVAL 64'h0

// byte address width of both sram ports
`define NPC_SRAM_ADDR_WD 64

`endif

// File: design/npc_pkg.sv
// shared enums for decode and execute, imported by the stages and the exec interface
package npc_pkg;

  // rv major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // alu operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B
  } alu_op_e;

  // branch unit function, jump is unconditional
  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_JUMP
  } br_func_e;

  // data memory access kind
  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

endpackage

// File: design/npc_ifaces.sv
// interfaces between the pipeline blocks: fetch to decode, and decode to the execute side
`timescale 1ns/1ps
`include "npc_settings.svh"

// valid/ready handshake from fetch to decode
interface fetch_if;
  logic                    valid;
  logic                    ready;
  logic [`NPC_WORD_WD-1:0] pc;
  logic [`NPC_INST_WD-1:0] inst;

  modport fs (output valid, output pc, output inst, input ready);
  modport ds (input valid, input pc, input inst, output ready);
endinterface

// decoded operands and controls, shared by exu, bru and lsu
interface exec_if import npc_pkg::*; ();
  logic [`NPC_WORD_WD-1:0]     rs1_data;
  logic [`NPC_WORD_WD-1:0]     rs2_data;
  logic [`NPC_WORD_WD-1:0]     imm;
  logic [`NPC_WORD_WD-1:0]     pc;
  alu_op_e                     alu_op;
  logic                        alu_b_imm;
  br_func_e                    br_func;
  mem_op_e                     mem_op;
  logic [`NPC_GPR_ADDR_WD-1:0] rd;
  logic                        rd_wen;
  // instruction executes this cycle
  logic                        fire;

  modport ds (
    output rs1_data, output rs2_data, output imm, output pc,
    output alu_op, output alu_b_imm, output br_func, output mem_op,
    output rd, output rd_wen, output fire
  );
  modport ex (
    input rs1_data, input rs2_data, input imm, input pc,
    input alu_op, input alu_b_imm, input br_func, input mem_op,
    input rd, input rd_wen, input fire
  );
endinterface

// File: design/npc_regfile.sv
// general-purpose register file, two asynchronous reads and one synchronous write
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_regfile (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic [`NPC_GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [`NPC_GPR_ADDR_WD-1:0] i_raddr2,
  output logic [`NPC_WORD_WD-1:0]     o_rdata1,
  output logic [`NPC_WORD_WD-1:0]     o_rdata2,
  input  logic                        i_wen,
  input  logic [`NPC_GPR_ADDR_WD-1:0] i_waddr,
  input  logic [`NPC_WORD_WD-1:0]     i_wdata
);

  localparam int NUM_REGS = 1 << `NPC_GPR_ADDR_WD;

  logic [`NPC_WORD_WD-1:0] regs [NUM_REGS];

  // x0 is never written
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: design/npc_if_stage.sv
// fetch stage: holds the pc, requests the instruction sram and presents words to decode
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_if_stage (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  fetch_if.fs                          fs,
  input  logic                         i_br_taken,
  input  logic [`NPC_WORD_WD-1:0]      i_br_target,
  input  logic                         i_halt,
  output logic                         o_inst_sram_en,
  output logic [`NPC_SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [`NPC_INST_WD-1:0]      i_inst_sram_rdata
);

  localparam logic [`NPC_WORD_WD-1:0] PC_STEP = 4;

  logic                    run_q;
  logic                    pend_q;
  logic                    redir_q;
  logic [`NPC_WORD_WD-1:0] pc_q;
  logic [`NPC_WORD_WD-1:0] tgt_q;
  logic [`NPC_WORD_WD-1:0] req_pc;

  // pc_q is the address of the word on the sram output
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      run_q   <= 1'b0;
      pend_q  <= 1'b0;
      redir_q <= 1'b0;
      pc_q    <= `NPC_PC_RESETVAL;
    end else begin
      run_q   <= 1'b1;
      redir_q <= i_br_taken;
      if (o_inst_sram_en) begin
        pc_q   <= req_pc;
        pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    tgt_q <= i_br_target;
  end

  // word fetched behind a taken branch is dropped
  assign fs.valid = pend_q && !redir_q;
  assign fs.pc    = pc_q;
  assign fs.inst  = i_inst_sram_rdata;

  assign req_pc = redir_q ? tgt_q : (pend_q ? pc_q + PC_STEP : pc_q);

  // no new request while decode holds the current word
  assign o_inst_sram_en   = run_q && !i_halt && (!fs.valid || fs.ready);
  assign o_inst_sram_addr = req_pc;

  // held word must not change under back-pressure
  a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    fs.valid && !fs.ready |=> fs.valid && $stable(fs.pc) && $stable(fs.inst));

  a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    pc_q[1:0] == 2'b00);

endmodule

// File: design/npc_id_stage.sv
// decode stage that decodes the instruction, reads the register file and stalls for loads
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_id_stage import npc_pkg::*; (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  fetch_if.ds                         ds,
  exec_if.ds                          ex,
  input  logic                        i_wb_wen,
  input  logic [`NPC_GPR_ADDR_WD-1:0] i_wb_addr,
  input  logic [`NPC_WORD_WD-1:0]     i_wb_data,
  output logic                        o_halt
);

  logic [`NPC_INST_WD-1:0] inst;
  opcode_e                 opcode;
  logic [2:0]              funct3;
  logic                    funct7_b5;
  logic [`NPC_WORD_WD-1:0] imm_i;
  logic [`NPC_WORD_WD-1:0] imm_s;
  logic [`NPC_WORD_WD-1:0] imm_b;
  logic [`NPC_WORD_WD-1:0] imm_j;
  logic [`NPC_WORD_WD-1:0] imm_u;
  logic                    is_ebreak;
  logic                    ld_stall_q;
  logic                    halt_q;

  assign inst      = ds.inst;
  assign opcode    = opcode_e'(inst[6:0]);
  assign funct3    = inst[14:12];
  assign funct7_b5 = inst[30];

  assign imm_i = {{(`NPC_WORD_WD-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(`NPC_WORD_WD-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(`NPC_WORD_WD-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                  inst[11:8], 1'b0};
  assign imm_j = {{(`NPC_WORD_WD-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};
  assign imm_u = {{(`NPC_WORD_WD-32){inst[31]}}, inst[31:12], 12'b0};

  // unknown encodings fall through as no-ops
  always_comb begin
    ex.alu_op    = ALU_ADD;
    ex.alu_b_imm = 1'b0;
    ex.br_func   = BR_NONE;
    ex.mem_op    = MEM_NONE;
    ex.rd_wen    = 1'b0;
    ex.imm       = imm_i;
    is_ebreak    = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        ex.alu_b_imm = 1'b1;
        ex.rd_wen    = (funct3 == 3'b000);
      end
      OPC_OP: begin
        ex.rd_wen = 1'b1;
        case ({funct7_b5, funct3})
          4'b0_000: ex.alu_op = ALU_ADD;
          4'b1_000: ex.alu_op = ALU_SUB;
          4'b0_111: ex.alu_op = ALU_AND;
          4'b0_110: ex.alu_op = ALU_OR;
          4'b0_100: ex.alu_op = ALU_XOR;
          4'b0_010: ex.alu_op = ALU_SLT;
          4'b0_001: ex.alu_op = ALU_SLL;
          4'b0_101: ex.alu_op = ALU_SRL;
          default:  ex.rd_wen = 1'b0;
        endcase
      end
      OPC_LUI: begin
        ex.alu_op    = ALU_PASS_B;
        ex.alu_b_imm = 1'b1;
        ex.imm       = imm_u;
        ex.rd_wen    = 1'b1;
      end
      OPC_BRANCH: begin
        // blt reads the signed compare from the alu
        ex.alu_op = ALU_SLT;
        ex.imm    = imm_b;
        case (funct3)
          3'b000:  ex.br_func = BR_EQ;
          3'b001:  ex.br_func = BR_NE;
          3'b100:  ex.br_func = BR_LT;
          default: ex.br_func = BR_NONE;
        endcase
      end
      OPC_JAL: begin
        ex.br_func = BR_JUMP;
        ex.imm     = imm_j;
        ex.rd_wen  = 1'b1;
      end
      OPC_LOAD: begin
        if (funct3 == 3'b011) begin
          ex.mem_op    = MEM_LOAD;
          ex.alu_b_imm = 1'b1;
          ex.rd_wen    = 1'b1;
        end
      end
      OPC_STORE: begin
        ex.imm = imm_s;
        if (funct3 == 3'b011) begin
          ex.mem_op    = MEM_STORE;
          ex.alu_b_imm = 1'b1;
        end
      end
      OPC_SYSTEM: is_ebreak = (inst == 32'h0010_0073);
      default: ;
    endcase
  end

  assign ds.ready = !ld_stall_q && !halt_q;
  assign ex.fire  = ds.valid && ds.ready;
  assign ex.pc    = ds.pc;
  assign ex.rd    = inst[11:7];
  assign o_halt   = halt_q;

  // second cycle of a load waits for the sram data
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ld_stall_q <= 1'b0;
      halt_q     <= 1'b0;
    end else begin
      ld_stall_q <= ex.fire && (ex.mem_op == MEM_LOAD);
      if (ex.fire && is_ebreak) begin
        halt_q <= 1'b1;
      end
    end
  end

  npc_regfile u_regfile (
    .i_clk    (i_clk         ),
    .i_rst_n  (i_rst_n       ),
    .i_raddr1 (inst[19:15]   ),
    .i_raddr2 (inst[24:20]   ),
    .o_rdata1 (ex.rs1_data   ),
    .o_rdata2 (ex.rs2_data   ),
    .i_wen    (i_wb_wen      ),
    .i_waddr  (i_wb_addr     ),
    .i_wdata  (i_wb_data     )
  );

  // the stall cycle carries the load's register write
  a_stall_writes: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    ld_stall_q |-> i_wb_wen);

endmodule

// File: design/npc_exu.sv
// execute unit: alu with second operand taken from rs2 or the immediate
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_exu import npc_pkg::*; (
  exec_if.ex                      ex,
  output logic [`NPC_WORD_WD-1:0] o_alu_result
);

  logic [`NPC_WORD_WD-1:0] op_a;
  logic [`NPC_WORD_WD-1:0] op_b;
  logic [5:0]              shamt;
  logic                    lt;

  assign op_a  = ex.rs1_data;
  assign op_b  = ex.alu_b_imm ? ex.imm : ex.rs2_data;
  // rv64 shifts use six bits
  assign shamt = op_b[5:0];
  assign lt    = $signed(op_a) < $signed(op_b);

  always_comb begin
    case (ex.alu_op)
      ALU_ADD:    o_alu_result = op_a + op_b;
      ALU_SUB:    o_alu_result = op_a - op_b;
      ALU_AND:    o_alu_result = op_a & op_b;
      ALU_OR:     o_alu_result = op_a | op_b;
      ALU_XOR:    o_alu_result = op_a ^ op_b;
      ALU_SLT:    o_alu_result = {{(`NPC_WORD_WD-1){1'b0}}, lt};
      ALU_SLL:    o_alu_result = op_a << shamt;
      ALU_SRL:    o_alu_result = op_a >> shamt;
      ALU_PASS_B: o_alu_result = op_b;
      default:    o_alu_result = op_a + op_b;
    endcase
  end

endmodule

// File: design/npc_bru.sv
// branch unit: decides taken branches and jumps and computes the redirect target
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_bru import npc_pkg::*; (
  exec_if.ex                      ex,
  input  logic [`NPC_WORD_WD-1:0] i_alu_result,
  output logic                    o_br_taken,
  output logic [`NPC_WORD_WD-1:0] o_br_target
);

  logic cond;

  always_comb begin
    case (ex.br_func)
      BR_EQ:   cond = (ex.rs1_data == ex.rs2_data);
      BR_NE:   cond = (ex.rs1_data != ex.rs2_data);
      // alu runs slt on rs1, rs2 for branches
      BR_LT:   cond = i_alu_result[0];
      BR_JUMP: cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  assign o_br_taken  = ex.fire && cond;
  assign o_br_target = ex.pc + ex.imm;

endmodule

// File: design/npc_lsu.sv
// load/store unit: drives the data sram and selects the register writeback value
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_lsu import npc_pkg::*; (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  exec_if.ex                           ex,
  input  logic [`NPC_WORD_WD-1:0]      i_alu_result,
  output logic                         o_data_sram_en,
  output logic                         o_data_sram_wen,
  output logic [`NPC_SRAM_ADDR_WD-1:0] o_data_sram_addr,
  output logic [`NPC_WORD_WD-1:0]      o_data_sram_wdata,
  input  logic [`NPC_WORD_WD-1:0]      i_data_sram_rdata,
  output logic                         o_wb_wen,
  output logic [`NPC_GPR_ADDR_WD-1:0]  o_wb_addr,
  output logic [`NPC_WORD_WD-1:0]      o_wb_data
);

  localparam logic [`NPC_WORD_WD-1:0] PC_STEP = 4;

  logic                        is_load;
  logic                        is_store;
  logic                        ld_pend_q;
  logic [`NPC_GPR_ADDR_WD-1:0] ld_rd_q;

  assign is_load  = ex.fire && (ex.mem_op == MEM_LOAD);
  assign is_store = ex.fire && (ex.mem_op == MEM_STORE);

  // address is rs1 plus imm from the alu
  assign o_data_sram_en    = is_load || is_store;
  assign o_data_sram_wen   = is_store;
  assign o_data_sram_addr  = i_alu_result;
  assign o_data_sram_wdata = ex.rs2_data;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ld_pend_q <= 1'b0;
    end else begin
      ld_pend_q <= is_load;
    end
  end

  always_ff @(posedge i_clk) begin
    if (is_load) begin
      ld_rd_q <= ex.rd;
    end
  end

  // load data returns while decode is stalled, so the two never collide
  always_comb begin
    if (ld_pend_q) begin
      o_wb_wen  = 1'b1;
      o_wb_addr = ld_rd_q;
      o_wb_data = i_data_sram_rdata;
    end else begin
      o_wb_wen  = ex.fire && ex.rd_wen && (ex.mem_op != MEM_LOAD);
      o_wb_addr = ex.rd;
      o_wb_data = (ex.br_func == BR_JUMP) ? ex.pc + PC_STEP : i_alu_result;
    end
  end

  a_store_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_data_sram_en && o_data_sram_wen |-> o_data_sram_addr[2:0] == 3'b000);

  a_load_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    ld_pend_q |-> !ex.fire);

endmodule

// File: design/npc_core.sv
// npc rv64i core top level, connects the stages to the instruction and data sram ports
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_core (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  output logic                         o_inst_sram_en,
  output logic [`NPC_SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [`NPC_INST_WD-1:0]      i_inst_sram_rdata,
  output logic                         o_data_sram_en,
  output logic                         o_data_sram_wen,
  output logic [`NPC_SRAM_ADDR_WD-1:0] o_data_sram_addr,
  output logic [`NPC_WORD_WD-1:0]      o_data_sram_wdata,
  input  logic [`NPC_WORD_WD-1:0]      i_data_sram_rdata,
  output logic                         o_halt
);

  logic                        br_taken;
  logic [`NPC_WORD_WD-1:0]     br_target;
  logic [`NPC_WORD_WD-1:0]     alu_result;
  logic                        wb_wen;
  logic [`NPC_GPR_ADDR_WD-1:0] wb_addr;
  logic [`NPC_WORD_WD-1:0]     wb_data;

  fetch_if fetch_bus ();
  exec_if  exec_bus ();

  npc_if_stage u_if_stage (
    .i_clk             (i_clk            ),
    .i_rst_n           (i_rst_n          ),
    .fs                (fetch_bus.fs     ),
    .i_br_taken        (br_taken         ),
    .i_br_target       (br_target        ),
    .i_halt            (o_halt           ),
    .o_inst_sram_en    (o_inst_sram_en   ),
    .o_inst_sram_addr  (o_inst_sram_addr ),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

  npc_id_stage u_id_stage (
    .i_clk             (i_clk            ),
    .i_rst_n           (i_rst_n          ),
    .ds                (fetch_bus.ds     ),
    .ex                (exec_bus.ds      ),
    .i_wb_wen          (wb_wen           ),
    .i_wb_addr         (wb_addr          ),
    .i_wb_data         (wb_data          ),
    .o_halt            (o_halt           )
  );

  npc_exu u_exu (
    .ex                (exec_bus.ex      ),
    .o_alu_result      (alu_result       )
  );

  npc_bru u_bru (
    .ex                (exec_bus.ex      ),
    .i_alu_result      (alu_result       ),
    .o_br_taken        (br_taken         ),
    .o_br_target       (br_target        )
  );

  npc_lsu u_lsu (
    .i_clk             (i_clk            ),
    .i_rst_n           (i_rst_n          ),
    .ex                (exec_bus.ex      ),
    .i_alu_result      (alu_result       ),
    .o_data_sram_en    (o_data_sram_en   ),
    .o_data_sram_wen   (o_data_sram_wen  ),
    .o_data_sram_addr  (o_data_sram_addr ),
    .o_data_sram_wdata (o_data_sram_wdata),
    .i_data_sram_rdata (i_data_sram_rdata),
    .o_wb_wen          (wb_wen           ),
    .o_wb_addr         (wb_addr          ),
    .o_wb_data         (wb_data          )
  );

endmodule

// File: verif/npc_tb_tasks.svh
// encoders, program loader and directed tests, included inside the npc testbench module
`ifndef NPC_TB_TASKS_SVH
`define NPC_TB_TASKS_SVH

function automatic logic [31:0] enc_r(int f7, int f3, int rd, int rs1, int rs2);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(int opc, int f3, int rd, int rs1, int imm);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic logic [31:0] sd(int rs2, int rs1, int imm);
  return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(int f3, int rs1, int rs2, int imm);
  return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] jal(int rd, int imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

function automatic logic [31:0] lui(int rd, int imm20);
  return {imm20[19:0], rd[4:0], 7'b0110111};
endfunction

function automatic logic [31:0] addi(int rd, int rs1, int imm);
  return enc_i(7'b0010011, 0, rd, rs1, imm);
endfunction

function automatic logic [31:0] ld(int rd, int rs1, int imm);
  return enc_i(7'b0000011, 3, rd, rs1, imm);
endfunction

function automatic logic [63:0] rand64();
  int hi;
  int lo;
  hi = $random(seed);
  lo = $random(seed);
  return {hi, lo};
endfunction

task automatic start_test(string name);
  test_name = name;
  err_base  = err_cnt;
  prog.delete();
  // background data differs at every index
  for (int i = 0; i < 256; i++) begin
    dmem[i] = {8'h5a, i[23:0], 8'ha5, i[23:0]};
  end
endtask

task automatic finish_test();
  tests_run = tests_run + 1;
  if (err_cnt == err_base) begin
    $display("%s: passed", test_name);
  end else begin
    tests_failed = tests_failed + 1;
    $display("%s: failed with %0d bad checks", test_name, err_cnt - err_base);
  end
endtask

task automatic check_value(string what, logic [63:0] exp, logic [63:0] act);
  if (exp !== act) begin
    $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    err_cnt = err_cnt + 1;
  end
endtask

task automatic check_store(int idx, logic [63:0] exp_addr, logic [63:0] exp_data);
  if (idx >= st_data.size()) begin
    $display("%s: store number %0d never happened", test_name, idx);
    err_cnt = err_cnt + 1;
  end else begin
    check_value($sformatf("store %0d address", idx), exp_addr, st_addr[idx]);
    check_value($sformatf("store %0d data", idx), exp_data, st_data[idx]);
  end
endtask

task automatic reset_core();
  @(negedge i_clk);
  i_rst_n = 1'b0;
  repeat (RESET_CYCLES) @(negedge i_clk);
  if (o_inst_sram_en || o_data_sram_en || o_data_sram_wen || o_halt) begin
    $display("%s: an sram enable or halt is high during reset", test_name);
    err_cnt = err_cnt + 1;
  end
  i_rst_n = 1'b1;
  repeat (3) @(negedge i_clk);
  if (fetch_cnt == 0) begin
    $display("%s: no instruction fetch after reset release", test_name);
    err_cnt = err_cnt + 1;
  end else begin
    check_value("first fetch address", 64'h0, first_fetch_addr);
  end
endtask

task automatic wait_halt();
  int n;
  n = 0;
  while (!o_halt && n < HALT_WAIT) begin
    @(negedge i_clk);
    n = n + 1;
  end
  if (!o_halt) begin
    $display("%s: core did not halt within %0d cycles", test_name, HALT_WAIT);
    err_cnt = err_cnt + 1;
  end
  repeat (4) @(negedge i_clk);
endtask

// unused words are no-ops carrying their own index
task automatic run_program();
  for (int i = 0; i < 256; i++) begin
    imem[i] = addi(0, 0, i);
  end
  foreach (prog[i]) begin
    imem[i] = prog[i];
  end
  reset_core();
  wait_halt();
endtask

task automatic alu_arith();
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] immx;
  int          r;
  start_test("alu_arith");
  a = rand64();
  b = rand64();
  r = $random(seed);
  immx = {{52{r[11]}}, r[11:0]};
  dmem[0] = a;
  dmem[1] = b;
  prog = '{ld(1, 0, 0), ld(2, 0, 8), addi(3, 1, r), enc_r(0, 0, 4, 1, 2),
           enc_r(32, 0, 5, 1, 2), enc_r(0, 7, 6, 1, 2), enc_r(0, 6, 7, 1, 2),
           enc_r(0, 4, 8, 1, 2)};
  for (int k = 0; k < 6; k++) begin
    prog.push_back(sd(k + 3, 0, 256 + 8 * k));
  end
  prog.push_back(32'h0010_0073);
  run_program();
  check_value("store count", 64'd6, 64'(st_data.size()));
  check_store(0, 256, a + immx);
  check_store(1, 264, a + b);
  check_store(2, 272, a - b);
  check_store(3, 280, a & b);
  check_store(4, 288, a | b);
  check_store(5, 296, a ^ b);
  finish_test();
endtask

task automatic compare_and_shift();
  logic [63:0] a;
  logic [63:0] b;
  int          sh;
  int          u;
  start_test("compare_and_shift");
  // negative against positive tells a signed compare from an unsigned one
  a  = rand64() | 64'h8000_0000_0000_0000;
  b  = rand64() & 64'h7fff_ffff_ffff_ffff;
  sh = $random(seed) & 63;
  u  = ($random(seed) & 32'h000f_ffff) | 32'h0008_0000;
  dmem[0] = a;
  dmem[1] = b;
  prog = '{ld(1, 0, 0), ld(2, 0, 8), enc_r(0, 2, 3, 1, 2), enc_r(0, 2, 4, 2, 1),
           addi(5, 0, sh), enc_r(0, 1, 6, 1, 5), enc_r(0, 5, 7, 1, 5), lui(8, u),
           enc_r(0, 0, 0, 1, 2), sd(3, 0, 320), sd(4, 0, 328), sd(6, 0, 336),
           sd(7, 0, 344), sd(8, 0, 352), sd(0, 0, 360), 32'h0010_0073};
  run_program();
  check_value("store count", 64'd6, 64'(st_data.size()));
  check_store(0, 320, ($signed(a) < $signed(b)) ? 64'd1 : 64'd0);
  check_store(1, 328, ($signed(b) < $signed(a)) ? 64'd1 : 64'd0);
  check_store(2, 336, a << sh);
  check_store(3, 344, a >> sh);
  check_store(4, 352, {{32{u[19]}}, u[19:0], 12'h000});
  check_store(5, 360, 64'h0);
  finish_test();
endtask

task automatic load_use();
  logic [63:0] v;
  start_test("load_use");
  v = rand64();
  dmem[4] = v;
  prog = '{ld(1, 0, 32), addi(2, 1, 123), sd(2, 0, 512), sd(1, 0, 520), 32'h0010_0073};
  run_program();
  check_value("store count", 64'd2, 64'(st_data.size()));
  check_store(0, 512, v + 64'd123);
  check_store(1, 520, v);
  finish_test();
endtask

task automatic branch_loop();
  start_test("branch_loop");
  prog = '{addi(1, 0, 5), sd(1, 0, 768), addi(1, 1, -1), enc_b(1, 1, 0, -8),
           addi(3, 3, 1), addi(2, 0, 1), enc_b(0, 1, 2, 8), sd(2, 0, 784),
           enc_b(4, 2, 1, 8), sd(2, 0, 792), sd(3, 0, 800), 32'h0010_0073};
  run_program();
  check_value("store count", 64'd8, 64'(st_data.size()));
  for (int k = 0; k < 5; k++) begin
    check_store(k, 768, 64'(5 - k));
  end
  check_store(5, 784, 64'd1);
  check_store(6, 792, 64'd1);
  check_store(7, 800, 64'd1);
  finish_test();
endtask

task automatic jal_link();
  start_test("jal_link");
  prog = '{addi(2, 0, 7), jal(1, 12), sd(2, 0, 1032), sd(2, 0, 1040),
           sd(1, 0, 1024), 32'h0010_0073};
  run_program();
  check_value("store count", 64'd1, 64'(st_data.size()));
  check_store(0, 1024, 64'd8);
  finish_test();
endtask

task automatic halt_and_reset();
  start_test("halt_and_reset");
  prog = '{addi(1, 0, 3), sd(1, 0, 64), 32'h0010_0073, sd(1, 0, 72), addi(1, 1, 1)};
  run_program();
  repeat (20) @(negedge i_clk);
  check_value("store count", 64'd1, 64'(st_data.size()));
  check_store(0, 64, 64'd3);
  check_value("fetches after halt", 64'd0, 64'(late_fetches));
  check_value("stores after halt", 64'd0, 64'(late_stores));
  // a second reset must restart from address zero
  reset_core();
  wait_halt();
  check_value("store count after reset", 64'd1, 64'(st_data.size()));
  finish_test();
endtask

`endif

// File: verif/npc_tb.sv
// testbench for the npc core: clock, reset, sram models, directed tests and the closing report
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_tb;

  localparam int CLK_HALF     = 2;
  localparam int RESET_CYCLES = 5;
  // six programs of at most 40 instructions, bubbles and reset included, plus margin
  localparam int CYCLE_LIMIT  = 2000;
  localparam int HALT_WAIT    = 300;

  logic                         i_clk;
  logic                         i_rst_n = 1'b0;
  logic                         o_inst_sram_en;
  logic [`NPC_SRAM_ADDR_WD-1:0] o_inst_sram_addr;
  logic [`NPC_INST_WD-1:0]      i_inst_sram_rdata = '0;
  logic                         o_data_sram_en;
  logic                         o_data_sram_wen;
  logic [`NPC_SRAM_ADDR_WD-1:0] o_data_sram_addr;
  logic [`NPC_WORD_WD-1:0]      o_data_sram_wdata;
  logic [`NPC_WORD_WD-1:0]      i_data_sram_rdata = '0;
  logic                         o_halt;

  logic [31:0] imem [256];
  logic [63:0] dmem [256];
  logic [31:0] prog [$];

  // requests seen at the last rising edge
  logic        inst_req_q  = 1'b0;
  logic [63:0] inst_addr_q = '0;
  logic        data_rd_q   = 1'b0;
  logic [63:0] data_addr_q = '0;

  // store log and fetch statistics since the last reset
  logic [63:0] st_addr [$];
  logic [63:0] st_data [$];
  int          fetch_cnt        = 0;
  logic [63:0] first_fetch_addr = '0;
  int          late_fetches     = 0;
  int          late_stores      = 0;

  int     cycles       = 0;
  int     err_cnt      = 0;
  int     err_base     = 0;
  int     tests_run    = 0;
  int     tests_failed = 0;
  integer seed         = 47;
  string  test_name    = "";

  npc_core npc_core_i (
    .i_clk             (i_clk            ),
    .i_rst_n           (i_rst_n          ),
    .o_inst_sram_en    (o_inst_sram_en   ),
    .o_inst_sram_addr  (o_inst_sram_addr ),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_data_sram_en    (o_data_sram_en   ),
    .o_data_sram_wen   (o_data_sram_wen  ),
    .o_data_sram_addr  (o_data_sram_addr ),
    .o_data_sram_wdata (o_data_sram_wdata),
    .i_data_sram_rdata (i_data_sram_rdata),
    .o_halt            (o_halt           )
  );

  initial begin
    i_clk = 1'b0;
    forever #CLK_HALF i_clk = ~i_clk;
  end

  // sram side: requests and writes are taken at the rising edge
  always @(posedge i_clk) begin
    inst_req_q  <= o_inst_sram_en;
    inst_addr_q <= o_inst_sram_addr;
    data_rd_q   <= o_data_sram_en && !o_data_sram_wen;
    data_addr_q <= o_data_sram_addr;
    if (!i_rst_n) begin
      st_addr.delete();
      st_data.delete();
      fetch_cnt    = 0;
      late_fetches = 0;
      late_stores  = 0;
    end else begin
      if (o_inst_sram_en) begin
        if (fetch_cnt == 0) begin
          first_fetch_addr = o_inst_sram_addr;
        end
        fetch_cnt = fetch_cnt + 1;
        if (o_halt) begin
          late_fetches = late_fetches + 1;
        end
      end
      if (o_data_sram_en && o_data_sram_wen) begin
        dmem[o_data_sram_addr[10:3]] = o_data_sram_wdata;
        st_addr.push_back(o_data_sram_addr);
        st_data.push_back(o_data_sram_wdata);
        if (o_halt) begin
          late_stores = late_stores + 1;
        end
      end
    end
  end

  // read data is answered on the falling edge
  always @(negedge i_clk) begin
    if (inst_req_q) begin
      i_inst_sram_rdata <= imem[inst_addr_q[9:2]];
    end
    if (data_rd_q) begin
      i_data_sram_rdata <= dmem[data_addr_q[10:3]];
    end
  end

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped: cycle limit of %0d reached in %s", CYCLE_LIMIT, test_name);
      $display("Errors found");
      $finish;
    end
  end

  `include "npc_tb_tasks.svh"

  initial begin
    alu_arith();
    compare_and_shift();
    load_use();
    branch_loop();
    jal_link();
    halt_and_reset();
    $display("%0d of %0d tests passed, %0d failed checks",
             tests_run - tests_failed, tests_run, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: npc.f
+incdir+design
+incdir+verif
design/npc_pkg.sv
design/npc_ifaces.sv
design/npc_regfile.sv
design/npc_if_stage.sv
design/npc_id_stage.sv
design/npc_exu.sv
design/npc_bru.sv
design/npc_lsu.sv
design/npc_core.sv
verif/npc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the npc testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module npc_tb -f npc.f -o npc_sim
./obj_dir/npc_sim | tee sim.log

if grep -q "No errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
